//--- hdl/mem_pkg.sv
package mem_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;

    // top two address bits pick the region
    localparam int REGION_MSB = 31;
    localparam int REGION_LSB = 30;

    typedef enum logic {
        RAM    = 1'b0,
        DEVICE = 1'b1
    } region_e;

    // byte offset below the word index
    localparam int WORD_LSB = 2;

    function automatic region_e region_of(addr_t addr);
        if (addr[REGION_MSB:REGION_LSB] == '0) begin
            return RAM;
        end
        return DEVICE;
    endfunction

endpackage

//--- hdl/access_route.sv
module access_route (
    input  logic           inst_rden,
    input  mem_pkg::addr_t inst_raddr,
    input  logic           data_rden,
    input  mem_pkg::addr_t data_raddr,
    input  logic           data_wren,
    input  mem_pkg::addr_t data_waddr,
    output logic           inst_ram_rden,
    output logic           data_ram_rden,
    output logic           data_ram_wren,
    output logic           data_dev_rden,
    output logic           data_dev_wren
);

    mem_pkg::region_e inst_rgn;
    mem_pkg::region_e rd_rgn;
    mem_pkg::region_e wr_rgn;

    assign inst_rgn = mem_pkg::region_of(inst_raddr);
    assign rd_rgn   = mem_pkg::region_of(data_raddr);
    assign wr_rgn   = mem_pkg::region_of(data_waddr);

    // instruction fetches from device space get no enable at all
    assign inst_ram_rden = inst_rden && (inst_rgn == mem_pkg::RAM);

    assign data_ram_rden = data_rden && (rd_rgn == mem_pkg::RAM);
    assign data_ram_wren = data_wren && (wr_rgn == mem_pkg::RAM);
    assign data_dev_rden = data_rden && (rd_rgn == mem_pkg::DEVICE);
    assign data_dev_wren = data_wren && (wr_rgn == mem_pkg::DEVICE);

endmodule

//--- hdl/line_cache.sv
module line_cache #(
    parameter int CACHE_LINES = 8
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           stall,
    input  logic           rden,
    input  mem_pkg::addr_t raddr,
    input  logic           wren,
    input  mem_pkg::addr_t waddr,
    input  mem_pkg::data_t wdata,
    output logic           busy,
    output logic           rvalid,
    output mem_pkg::addr_t roaddr,
    output mem_pkg::data_t rdata,
    output logic           mem_req,
    output logic           mem_write,
    output mem_pkg::addr_t mem_addr,
    output mem_pkg::data_t mem_wdata,
    input  logic           mem_ack,
    input  mem_pkg::data_t mem_rdata
);

    localparam int IDX_W = $clog2(CACHE_LINES);
    localparam int TAG_W = mem_pkg::ADDR_W - mem_pkg::WORD_LSB - IDX_W;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_REL
    } state_e;

    state_e                 state;
    logic [CACHE_LINES-1:0] valid;
    logic [TAG_W-1:0]       tag_mem [CACHE_LINES];
    mem_pkg::data_t         data_mem [CACHE_LINES];
    logic                   wr_done;

    logic [IDX_W-1:0] ridx;
    logic [IDX_W-1:0] widx;
    logic [IDX_W-1:0] fidx;
    logic [TAG_W-1:0] rtag;
    logic [TAG_W-1:0] wtag;
    logic [TAG_W-1:0] ftag;
    logic             rhit;
    logic             whit;
    logic             rd_miss;
    logic             wr_pend;

    assign ridx = raddr[mem_pkg::WORD_LSB +: IDX_W];
    assign widx = waddr[mem_pkg::WORD_LSB +: IDX_W];
    assign fidx = mem_addr[mem_pkg::WORD_LSB +: IDX_W];
    assign rtag = raddr[mem_pkg::ADDR_W-1 -: TAG_W];
    assign wtag = waddr[mem_pkg::ADDR_W-1 -: TAG_W];
    assign ftag = mem_addr[mem_pkg::ADDR_W-1 -: TAG_W];

    assign rhit    = valid[ridx] && (tag_mem[ridx] == rtag);
    assign whit    = valid[widx] && (tag_mem[widx] == wtag);
    assign rd_miss = rden && !rhit;
    assign wr_pend = wren && !wr_done;

    // a finished fill turns the read into a hit once the link is idle again
    assign busy = rd_miss || wr_pend || (state != ST_IDLE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            mem_req <= 1'b0;
            valid   <= '0;
            wr_done <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            rvalid <= rden && !stall;
            if (!stall) begin
                wr_done <= 1'b0;
            end
            case (state)
                ST_IDLE: begin
                    // write goes out before any fill
                    if (wr_pend || rd_miss) begin
                        mem_req <= 1'b1;
                        state   <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (mem_ack) begin
                        mem_req <= 1'b0;
                        state   <= ST_REL;
                        if (!mem_write) begin
                            valid[fidx] <= 1'b1;
                        end
                    end
                end
                ST_REL: begin
                    if (!mem_ack) begin
                        state <= ST_IDLE;
                        if (mem_write) begin
                            wr_done <= 1'b1;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            roaddr <= raddr;
            rdata  <= data_mem[ridx];
        end
        if (state == ST_IDLE) begin
            if (wr_pend) begin
                mem_write <= 1'b1;
                mem_addr  <= waddr;
                mem_wdata <= wdata;
                // writes always go out and refresh the line only on a hit
                if (whit) begin
                    data_mem[widx] <= wdata;
                end
            end else if (rd_miss) begin
                mem_write <= 1'b0;
                mem_addr  <= raddr;
                mem_wdata <= '0;
            end
        end
        if ((state == ST_REQ) && mem_ack && !mem_write) begin
            tag_mem[fidx]  <= ftag;
            data_mem[fidx] <= mem_rdata;
        end
    end

endmodule

//--- hdl/device_port.sv
module device_port (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           stall,
    input  logic           rden,
    input  mem_pkg::addr_t raddr,
    input  logic           wren,
    input  mem_pkg::addr_t waddr,
    input  mem_pkg::data_t wdata,
    output logic           loading,
    output logic           rvalid,
    output mem_pkg::addr_t roaddr,
    output mem_pkg::data_t rdata,
    output logic           mem_req,
    output logic           mem_write,
    output mem_pkg::addr_t mem_addr,
    output mem_pkg::data_t mem_wdata,
    input  logic           mem_ack,
    input  mem_pkg::data_t mem_rdata
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_REL
    } state_e;

    state_e state;
    logic   wr_done;
    logic   rd_done;
    logic   wr_pend;
    logic   rd_pend;

    // done flags hold until the pipeline takes the access
    assign wr_pend = wren && !wr_done;
    assign rd_pend = rden && !rd_done;
    assign loading = wr_pend || rd_pend || (state != ST_IDLE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            mem_req <= 1'b0;
            wr_done <= 1'b0;
            rd_done <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            rvalid <= rden && !stall;
            if (!stall) begin
                wr_done <= 1'b0;
                rd_done <= 1'b0;
            end
            case (state)
                ST_IDLE: begin
                    if (wr_pend || rd_pend) begin
                        mem_req <= 1'b1;
                        state   <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (mem_ack) begin
                        mem_req <= 1'b0;
                        state   <= ST_REL;
                    end
                end
                ST_REL: begin
                    if (!mem_ack) begin
                        state   <= ST_IDLE;
                        wr_done <= wr_done || mem_write;
                        rd_done <= rd_done || !mem_write;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            roaddr <= raddr;
        end
        if ((state == ST_IDLE) && wr_pend) begin
            mem_write <= 1'b1;
            mem_addr  <= waddr;
            mem_wdata <= wdata;
        end else if ((state == ST_IDLE) && rd_pend) begin
            mem_write <= 1'b0;
            mem_addr  <= raddr;
            mem_wdata <= '0;
        end
        if ((state == ST_REQ) && mem_ack && !mem_write) begin
            rdata <= mem_rdata;
        end
    end

endmodule

//--- hdl/bus_arbiter.sv
module bus_arbiter (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           inst_req,
    input  logic           inst_write,
    input  mem_pkg::addr_t inst_addr,
    input  mem_pkg::data_t inst_wdata,
    output logic           inst_ack,
    output mem_pkg::data_t inst_rdata,
    input  logic           data_req,
    input  logic           data_write,
    input  mem_pkg::addr_t data_addr,
    input  mem_pkg::data_t data_wdata,
    output logic           data_ack,
    output mem_pkg::data_t data_rdata,
    input  logic           dev_req,
    input  logic           dev_write,
    input  mem_pkg::addr_t dev_addr,
    input  mem_pkg::data_t dev_wdata,
    output logic           dev_ack,
    output mem_pkg::data_t dev_rdata,
    output logic           bus_req,
    output logic           bus_write,
    output mem_pkg::addr_t bus_addr,
    output mem_pkg::data_t bus_wdata,
    input  logic           bus_ack,
    input  mem_pkg::data_t bus_rdata
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUS,
        ST_HOLD,
        ST_DRAIN
    } state_e;

    state_e         state;
    // one-hot with bit 0 inst, bit 1 data and bit 2 device
    logic [2:0]     grant;
    logic [2:0]     pick;
    logic           pick_write;
    mem_pkg::addr_t pick_addr;
    mem_pkg::data_t pick_wdata;
    logic           link_ack;
    logic           sel_req;
    logic           start;
    mem_pkg::data_t rdata_q;

    assign sel_req = |(grant & {dev_req, data_req, inst_req});
    assign start   = (state == ST_IDLE) && (inst_req || data_req || dev_req) && !bus_ack;

    always_comb begin
        pick       = 3'b100;
        pick_write = dev_write;
        pick_addr  = dev_addr;
        pick_wdata = dev_wdata;
        if (inst_req) begin
            pick       = 3'b001;
            pick_write = inst_write;
            pick_addr  = inst_addr;
            pick_wdata = inst_wdata;
        end else if (data_req) begin
            pick       = 3'b010;
            pick_write = data_write;
            pick_addr  = data_addr;
            pick_wdata = data_wdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            grant    <= '0;
            bus_req  <= 1'b0;
            link_ack <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        grant   <= pick;
                        bus_req <= 1'b1;
                        state   <= ST_BUS;
                    end
                end
                ST_BUS: begin
                    if (bus_ack) begin
                        bus_req  <= 1'b0;
                        link_ack <= 1'b1;
                        state    <= ST_HOLD;
                    end
                end
                ST_HOLD: begin
                    // requester has seen ack and let go
                    if (!sel_req) begin
                        link_ack <= 1'b0;
                        state    <= ST_DRAIN;
                    end
                end
                ST_DRAIN: begin
                    if (!bus_ack) begin
                        grant <= '0;
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            bus_write <= pick_write;
            bus_addr  <= pick_addr;
            bus_wdata <= pick_wdata;
        end
        if ((state == ST_BUS) && bus_ack) begin
            rdata_q <= bus_rdata;
        end
    end

    assign inst_ack   = link_ack && grant[0];
    assign data_ack   = link_ack && grant[1];
    assign dev_ack    = link_ack && grant[2];
    assign inst_rdata = rdata_q;
    assign data_rdata = rdata_q;
    assign dev_rdata  = rdata_q;

endmodule

//--- hdl/mem_unit.sv
module mem_unit #(
    parameter int CACHE_LINES = 8
) (
    input  logic           clk,
    input  logic           rst_n,
    output logic           mem_wait,
    input  logic           inst_rden,
    input  mem_pkg::addr_t inst_raddr,
    output logic           inst_rvalid,
    output mem_pkg::addr_t inst_roaddr,
    output mem_pkg::data_t inst_rdata,
    input  logic           data_rden,
    input  mem_pkg::addr_t data_raddr,
    output logic           data_rvalid,
    output mem_pkg::addr_t data_roaddr,
    output mem_pkg::data_t data_rdata,
    input  logic           data_wren,
    input  mem_pkg::addr_t data_waddr,
    input  mem_pkg::data_t data_wdata,
    output logic           bus_req,
    output logic           bus_write,
    output mem_pkg::addr_t bus_addr,
    output mem_pkg::data_t bus_wdata,
    input  logic           bus_ack,
    input  mem_pkg::data_t bus_rdata
);

    logic inst_ram_rden;
    logic data_ram_rden;
    logic data_ram_wren;
    logic data_dev_rden;
    logic data_dev_wren;

    logic ic_busy;
    logic dc_busy;
    logic dev_loading;

    logic           dc_rvalid;
    mem_pkg::addr_t dc_roaddr;
    mem_pkg::data_t dc_rdata;
    logic           dev_rvalid;
    mem_pkg::addr_t dev_roaddr;
    mem_pkg::data_t dev_rdata;

    // req/ack links toward the arbiter
    logic           ic_req;
    logic           ic_write;
    logic           ic_ack;
    mem_pkg::addr_t ic_addr;
    mem_pkg::data_t ic_wdata;
    mem_pkg::data_t ic_rdata;
    logic           dc_req;
    logic           dc_write;
    logic           dc_ack;
    mem_pkg::addr_t dc_addr;
    mem_pkg::data_t dc_wdata;
    mem_pkg::data_t dc_rdata_link;
    logic           dv_req;
    logic           dv_write;
    logic           dv_ack;
    mem_pkg::addr_t dv_addr;
    mem_pkg::data_t dv_wdata;
    mem_pkg::data_t dv_rdata;

    assign mem_wait = ic_busy || dc_busy || dev_loading;

    // at most one of the two returns is valid per cycle
    assign data_rvalid = dc_rvalid || dev_rvalid;
    assign data_roaddr = dev_rvalid ? dev_roaddr : dc_roaddr;
    assign data_rdata  = dev_rvalid ? dev_rdata : dc_rdata;

    access_route route0 (
        .inst_rden(inst_rden), .inst_raddr(inst_raddr),
        .data_rden(data_rden), .data_raddr(data_raddr),
        .data_wren(data_wren), .data_waddr(data_waddr),
        .inst_ram_rden(inst_ram_rden),
        .data_ram_rden(data_ram_rden), .data_ram_wren(data_ram_wren),
        .data_dev_rden(data_dev_rden), .data_dev_wren(data_dev_wren)
    );

    // instruction side never writes
    line_cache #(.CACHE_LINES(CACHE_LINES)) inst_cache (
        .clk(clk), .rst_n(rst_n), .stall(mem_wait),
        .rden(inst_ram_rden), .raddr(inst_raddr),
        .wren(1'b0), .waddr('0), .wdata('0),
        .busy(ic_busy), .rvalid(inst_rvalid), .roaddr(inst_roaddr), .rdata(inst_rdata),
        .mem_req(ic_req), .mem_write(ic_write), .mem_addr(ic_addr), .mem_wdata(ic_wdata),
        .mem_ack(ic_ack), .mem_rdata(ic_rdata)
    );

    line_cache #(.CACHE_LINES(CACHE_LINES)) data_cache (
        .clk(clk), .rst_n(rst_n), .stall(mem_wait),
        .rden(data_ram_rden), .raddr(data_raddr),
        .wren(data_ram_wren), .waddr(data_waddr), .wdata(data_wdata),
        .busy(dc_busy), .rvalid(dc_rvalid), .roaddr(dc_roaddr), .rdata(dc_rdata),
        .mem_req(dc_req), .mem_write(dc_write), .mem_addr(dc_addr), .mem_wdata(dc_wdata),
        .mem_ack(dc_ack), .mem_rdata(dc_rdata_link)
    );

    device_port device0 (
        .clk(clk), .rst_n(rst_n), .stall(mem_wait),
        .rden(data_dev_rden), .raddr(data_raddr),
        .wren(data_dev_wren), .waddr(data_waddr), .wdata(data_wdata),
        .loading(dev_loading), .rvalid(dev_rvalid), .roaddr(dev_roaddr), .rdata(dev_rdata),
        .mem_req(dv_req), .mem_write(dv_write), .mem_addr(dv_addr), .mem_wdata(dv_wdata),
        .mem_ack(dv_ack), .mem_rdata(dv_rdata)
    );

    bus_arbiter arbiter0 (
        .clk(clk), .rst_n(rst_n),
        .inst_req(ic_req), .inst_write(ic_write), .inst_addr(ic_addr),
        .inst_wdata(ic_wdata), .inst_ack(ic_ack), .inst_rdata(ic_rdata),
        .data_req(dc_req), .data_write(dc_write), .data_addr(dc_addr),
        .data_wdata(dc_wdata), .data_ack(dc_ack), .data_rdata(dc_rdata_link),
        .dev_req(dv_req), .dev_write(dv_write), .dev_addr(dv_addr),
        .dev_wdata(dv_wdata), .dev_ack(dv_ack), .dev_rdata(dv_rdata),
        .bus_req(bus_req), .bus_write(bus_write), .bus_addr(bus_addr),
        .bus_wdata(bus_wdata), .bus_ack(bus_ack), .bus_rdata(bus_rdata)
    );

endmodule

//--- dv/clk_gen.sv
module clk_gen #(
    parameter int PERIOD = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always begin
        #(PERIOD / 2) clk = ~clk;
    end

endmodule

//--- dv/mem_unit_chk.sv
module mem_unit_chk (
    input logic           clk,
    input logic           rst_n,
    input logic           mem_wait,
    input logic           inst_rden,
    input logic           inst_rvalid,
    input logic           data_rden,
    input logic           data_rvalid,
    input logic           bus_req,
    input logic           bus_write,
    input mem_pkg::addr_t bus_addr,
    input mem_pkg::data_t bus_wdata,
    input logic           bus_ack
);

    // count of failed assertions, read back by the testbench
    int fails = 0;

    // fields frozen for the whole request phase
    bus_fields_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (bus_req && $past(bus_req)) |->
            ($stable(bus_addr) && $stable(bus_write) && $stable(bus_wdata)))
        else begin
            $error("bus fields changed while bus_req was high");
            fails++;
        end

    bus_req_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(bus_req) |-> !$past(bus_ack))
        else begin
            $error("bus_req rose while bus_ack was still high");
            fails++;
        end

    bus_req_in_reset: assert property (@(posedge clk)
        !rst_n |-> !bus_req)
        else begin
            $error("bus_req high during reset");
            fails++;
        end

    // a return only follows an edge that took a read
    inst_return: assert property (@(posedge clk) disable iff (!rst_n)
        inst_rvalid |-> $past(inst_rden && !mem_wait))
        else begin
            $error("inst_rvalid without an accepted instruction read");
            fails++;
        end

    data_return: assert property (@(posedge clk) disable iff (!rst_n)
        data_rvalid |-> $past(data_rden && !mem_wait))
        else begin
            $error("data_rvalid without an accepted data read");
            fails++;
        end

endmodule

//--- dv/tb_mem_unit.sv
module tb_mem_unit;

    localparam int          CLK_PERIOD = 100;
    localparam logic [31:0] LFSR_SEED  = 32'h4fe77ca5;
    localparam int          OP_CYCLES  = 40;
    localparam int          MAX_LINES  = 64;
    localparam logic [31:0] FILL_MASK  = 32'h5a5a0000;

    logic        clk;
    logic        rst_n;
    logic        mem_wait;
    logic        inst_rden;
    logic [31:0] inst_raddr;
    logic        inst_rvalid;
    logic [31:0] inst_roaddr;
    logic [31:0] inst_rdata;
    logic        data_rden;
    logic [31:0] data_raddr;
    logic        data_rvalid;
    logic [31:0] data_roaddr;
    logic [31:0] data_rdata;
    logic        data_wren;
    logic [31:0] data_waddr;
    logic [31:0] data_wdata;
    logic        bus_req;
    logic        bus_write;
    logic [31:0] bus_addr;
    logic [31:0] bus_wdata;
    logic        bus_ack;
    logic [31:0] bus_rdata;

    logic [31:0] stim [4*MAX_LINES];
    logic [31:0] ram_mem [logic [31:0]];
    logic [31:0] dev_mem [logic [31:0]];
    logic [31:0] bus_log [$];
    logic [31:0] lfsr        = LFSR_SEED;
    int          ram_reqs    = 0;
    int          dev_reqs    = 0;
    int          errors      = 0;
    int          checks      = 0;
    int          tests       = 0;
    int          cycles      = 0;
    int          cycle_limit = 4 + OP_CYCLES * MAX_LINES;

    clk_gen #(.PERIOD(CLK_PERIOD)) clk_gen0 (.clk(clk));

    mem_unit #(.CACHE_LINES(8)) dut0 (
        .clk(clk), .rst_n(rst_n), .mem_wait(mem_wait),
        .inst_rden(inst_rden), .inst_raddr(inst_raddr),
        .inst_rvalid(inst_rvalid), .inst_roaddr(inst_roaddr), .inst_rdata(inst_rdata),
        .data_rden(data_rden), .data_raddr(data_raddr),
        .data_rvalid(data_rvalid), .data_roaddr(data_roaddr), .data_rdata(data_rdata),
        .data_wren(data_wren), .data_waddr(data_waddr), .data_wdata(data_wdata),
        .bus_req(bus_req), .bus_write(bus_write), .bus_addr(bus_addr),
        .bus_wdata(bus_wdata), .bus_ack(bus_ack), .bus_rdata(bus_rdata)
    );

    bind mem_unit mem_unit_chk chk0 (
        .clk(clk), .rst_n(rst_n), .mem_wait(mem_wait),
        .inst_rden(inst_rden), .inst_rvalid(inst_rvalid),
        .data_rden(data_rden), .data_rvalid(data_rvalid),
        .bus_req(bus_req), .bus_write(bus_write), .bus_addr(bus_addr),
        .bus_wdata(bus_wdata), .bus_ack(bus_ack)
    );

    function automatic logic ram_region(input logic [31:0] addr);
        return addr[31:30] == 2'b00;
    endfunction

    // untouched words follow the fill rule
    function automatic logic [31:0] model_word(input logic [31:0] addr);
        if (ram_region(addr) && ram_mem.exists(addr)) begin
            return ram_mem[addr];
        end
        if (!ram_region(addr) && dev_mem.exists(addr)) begin
            return dev_mem[addr];
        end
        return addr ^ FILL_MASK;
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    task automatic take_bits(input int n, output int unsigned val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            val  = (val << 1) | lfsr[0];
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond === 1'b1) else begin
            $display("error: %s", what);
            errors++;
        end
    endtask

    task automatic drive_idle();
        inst_rden  = 1'b0;
        inst_raddr = '0;
        data_rden  = 1'b0;
        data_raddr = '0;
        data_wren  = 1'b0;
        data_waddr = '0;
        data_wdata = '0;
    endtask

    // bus memory model that acks 1 to 4 cycles after it sees the request
    always begin : bus_model
        int unsigned delay;
        @(negedge clk);
        if (rst_n && bus_req && !bus_ack) begin
            bus_log.push_back(bus_addr);
            if (ram_region(bus_addr)) begin
                ram_reqs++;
            end else begin
                dev_reqs++;
            end
            take_bits(2, delay);
            repeat (delay + 1) @(negedge clk);
            if (bus_write && ram_region(bus_addr)) begin
                ram_mem[bus_addr] = bus_wdata;
            end else if (bus_write) begin
                dev_mem[bus_addr] = bus_wdata;
            end else begin
                bus_rdata = model_word(bus_addr);
            end
            bus_ack = 1'b1;
            do begin
                @(negedge clk);
            end while (bus_req);
            bus_ack = 1'b0;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("test failed");
            $finish;
        end
    end

    task automatic check_reset_quiet();
        int errs_before;
        errs_before = errors;
        tests++;
        repeat (6) begin
            @(negedge clk);
            check_value("mem_wait", 32'h0, {31'h0, mem_wait});
            check_value("bus_req", 32'h0, {31'h0, bus_req});
            check_value("inst_rvalid", 32'h0, {31'h0, inst_rvalid});
            check_value("data_rvalid", 32'h0, {31'h0, data_rvalid});
        end
        $display("reset idle: %s", (errors == errs_before) ? "ok" : "error");
    endtask

    task automatic run_line(input int idx, output int used);
        logic [31:0] op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] expected;
        logic [31:0] p_addr;
        logic [31:0] p_expected;
        logic        i_valid;
        logic [31:0] i_addr;
        logic [31:0] i_data;
        logic        d_valid;
        logic [31:0] d_addr;
        logic [31:0] d_data;
        int          ram_before;
        int          dev_before;
        int          log_before;
        int          errs_before;
        string       label;

        op         = stim[4*idx];
        addr       = stim[4*idx+1];
        wdata      = stim[4*idx+2];
        expected   = stim[4*idx+3];
        p_addr     = stim[4*idx+5];
        p_expected = stim[4*idx+7];
        used        = (op[3:0] == 4'd4) ? 2 : 1;
        errs_before = errors;
        label       = "unknown op";
        tests++;

        @(negedge clk);
        ram_before = ram_reqs;
        dev_before = dev_reqs;
        log_before = bus_log.size();
        case (op[3:0])
            4'd1: begin
                inst_rden  = 1'b1;
                inst_raddr = addr;
                label      = "inst read";
            end
            4'd2: begin
                data_rden  = 1'b1;
                data_raddr = addr;
                label      = "data read";
            end
            4'd3: begin
                data_wren  = 1'b1;
                data_waddr = addr;
                data_wdata = wdata;
                label      = "data write";
            end
            4'd4: begin
                inst_rden  = 1'b1;
                inst_raddr = addr;
                data_rden  = 1'b1;
                data_raddr = p_addr;
                label      = "paired read";
            end
            default: begin
                check_true(1'b0, "unknown operation code in the stimulus file");
            end
        endcase

        // held until an edge with mem_wait low takes it
        @(posedge clk);
        while (mem_wait) begin
            @(posedge clk);
        end
        @(negedge clk);
        i_valid = inst_rvalid;
        i_addr  = inst_roaddr;
        i_data  = inst_rdata;
        d_valid = data_rvalid;
        d_addr  = data_roaddr;
        d_data  = data_rdata;
        drive_idle();

        if (op[3:0] == 4'd1 || op[3:0] == 4'd4) begin
            check_true(i_valid, "instruction read gave no return");
            check_value("inst_roaddr", addr, i_addr);
            check_value("inst_rdata", expected, i_data);
        end
        if (op[3:0] == 4'd2) begin
            check_true(d_valid, "data read gave no return");
            check_value("data_roaddr", addr, d_addr);
            check_value("data_rdata", expected, d_data);
        end
        if (op[3:0] == 4'd3) begin
            check_value("bus model word", expected, model_word(addr));
        end
        if (op[3:0] == 4'd4) begin
            check_true(stim[4*idx+4][3:0] == 4'd2,
                       "paired instruction read is not followed by a data read");
            check_true(d_valid, "paired data read gave no return");
            check_value("data_roaddr", p_addr, d_addr);
            check_value("data_rdata", p_expected, d_data);
            check_true(bus_log.size() > log_before, "paired reads made no bus request");
            if (bus_log.size() > log_before) begin
                check_value("first bus_addr", addr, bus_log[log_before]);
            end
        end
        check_value("ram bus requests", op[7:4], ram_reqs - ram_before);
        check_value("device bus requests", op[11:8], dev_reqs - dev_before);

        $display("line %0d %s at %h: %s", idx + 1, label, addr,
                 (errors == errs_before) ? "ok" : "error");
    endtask

    initial begin
        int num_lines;
        int line;
        int used;

        rst_n     = 1'b0;
        bus_ack   = 1'b0;
        bus_rdata = '0;
        drive_idle();
        for (int i = 0; i < 4 * MAX_LINES; i++) begin
            stim[i] = '0;
        end
        $readmemh("dv/mem_stimulus.txt", stim);
        num_lines = 0;
        while (num_lines < MAX_LINES && stim[4*num_lines] != '0) begin
            num_lines++;
        end
        cycle_limit = 4 + OP_CYCLES * num_lines;
        check_true(num_lines > 0, "stimulus file holds no operations");

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        check_reset_quiet();
        line = 0;
        while (line < num_lines) begin
            run_line(line, used);
            line += used;
        end

        $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
                 tests, checks, errors, dut0.chk0.fails);
        if (errors == 0 && dut0.chk0.fails == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- dv/mem_stimulus.txt
// columns: op, address, write data, expected word
// op hex digits: device bus reqs, ram bus reqs, code (1 inst rd, 2 data rd, 3 write, 4 paired)
// code 4 is issued with the data read on the next line; its counts cover both
011 00000100 00000000 5a5a0100
001 00000100 00000000 5a5a0100
011 00000104 00000000 5a5a0104
012 00000200 00000000 5a5a0200
013 00000200 12345678 12345678
002 00000200 00000000 12345678
013 00000300 cafe0001 cafe0001
012 00000300 00000000 cafe0001
102 80000010 00000000 da5a0010
102 80000010 00000000 da5a0010
103 c0000020 0badf00d 0badf00d
103 c0000020 0badf00d 0badf00d
102 c0000020 00000000 0badf00d
012 00000040 00000000 5a5a0040
012 00000060 00000000 5a5a0060
012 00000040 00000000 5a5a0040
012 00000060 00000000 5a5a0060
024 00000400 00000000 5a5a0400
002 00000500 00000000 5a5a0500
001 00000400 00000000 5a5a0400
002 00000500 00000000 5a5a0500

//--- tb.f
hdl/mem_pkg.sv
hdl/access_route.sv
hdl/line_cache.sv
hdl/device_port.sv
hdl/bus_arbiter.sv
hdl/mem_unit.sv
dv/clk_gen.sv
dv/mem_unit_chk.sv
dv/tb_mem_unit.sv
